// ==== mam_cfg.svh ====
// ------------------------------------------------
// Bus and memory sizes for the debug memory access
// RTL and its testbench, included where a width
// or the memory depth is needed
// ------------------------------------------------
`ifndef MAM_CFG_SVH
`define MAM_CFG_SVH

`define MAM_DATA_WIDTH 16                    // Bus data width in bits
`define MAM_ADDR_WIDTH 32                    // Byte address
`define MAM_SEL_WIDTH  (`MAM_DATA_WIDTH / 8) // One select per byte
`define MAM_MEM_WORDS  256                   // Memory depth, addresses wrap

`endif

// ==== mam_pkg.sv ====
// ------------------------------------------------
// Enumerated types shared by the bridge, the arbiter
// and the memory. Modules import it in their body
// ------------------------------------------------
package mam_pkg;

   // Request direction as seen on req_rw_i
   typedef enum logic {
      MAM_READ  = 1'b0,
      MAM_WRITE = 1'b1
   } mam_op_e;

   // Wishbone B3 cycle type identifier
   typedef enum logic [2:0] {
      CTI_CLASSIC = 3'b000,
      CTI_INCR    = 3'b010,                  // Incrementing burst
      CTI_END     = 3'b111                   // Last beat of a cycle
   } wb_cti_e;

   // Bridge FSM states
   typedef enum logic [3:0] {
      STATE_IDLE,
      STATE_WRITE_LAST,                      // Final write beat on the bus
      STATE_WRITE_LAST_WAIT,                 // Final beat waits for data
      STATE_WRITE,
      STATE_WRITE_WAIT,
      STATE_READ_LAST,                       // Single read on the bus
      STATE_READ_LAST_BURST,                 // Final burst beat on the bus
      STATE_READ_LAST_WAIT,                  // Last word waits for the reader
      STATE_READ_START,                      // cyc up, stb follows next clock
      STATE_READ,
      STATE_READ_WAIT
   } mam_state_e;

endpackage

// ==== mam_wb_if.sv ====
// ------------------------------------------------
// Bridge from the request, write and read channels
// to a Wishbone B3 master. Single beats use the byte
// strobe, bursts increment the address per beat
// ------------------------------------------------
`timescale 1ns/1ns
`include "mam_cfg.svh"

module mam_wb_if (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       req_valid_i,
   output logic                       req_ready_o,
   input  mam_pkg::mam_op_e           req_rw_i,
   input  logic [`MAM_ADDR_WIDTH-1:0] req_addr_i,
   input  logic                       req_burst_i,
   input  logic [13:0]                req_beats_i,   // Words in a burst
   input  logic                       write_valid_i,
   input  logic [`MAM_DATA_WIDTH-1:0] write_data_i,
   input  logic [`MAM_SEL_WIDTH-1:0]  write_strb_i,  // Single beats only
   output logic                       write_ready_o,
   output logic                       read_valid_o,
   output logic [`MAM_DATA_WIDTH-1:0] read_data_o,
   input  logic                       read_ready_i,
   output logic                       stb_o,
   output logic                       cyc_o,
   output logic                       we_o,
   output logic [`MAM_ADDR_WIDTH-1:0] addr_o,
   output logic [`MAM_DATA_WIDTH-1:0] dat_o,
   output logic [`MAM_SEL_WIDTH-1:0]  sel_o,
   output mam_pkg::wb_cti_e           cti_o,
   output logic [1:0]                 bte_o,
   input  logic                       ack_i,
   input  logic [`MAM_DATA_WIDTH-1:0] dat_i
);
   import mam_pkg::*;

   mam_state_e                 state, nxt_state;
   logic                       nxt_stb, nxt_cyc, nxt_we;
   wb_cti_e                    nxt_cti;
   logic [`MAM_ADDR_WIDTH-1:0] nxt_addr, addr_step;
   logic [`MAM_DATA_WIDTH-1:0] nxt_dat, read_q, nxt_read;
   logic [`MAM_SEL_WIDTH-1:0]  nxt_sel;
   logic [13:0]                beats, nxt_beats, beats_dec;
   logic                       burst_q, nxt_burst;
   logic                       is_write;

   // Pick the write state from the beats left and the data on hand
   function automatic mam_state_e write_state(input logic last, input logic have_data);
      if (last) begin
         return have_data ? STATE_WRITE_LAST : STATE_WRITE_LAST_WAIT;
      end
      return have_data ? STATE_WRITE : STATE_WRITE_WAIT;
   endfunction

   assign addr_step   = `MAM_SEL_WIDTH;       // One word in bytes
   assign beats_dec   = beats - 14'd1;
   assign is_write    = (req_rw_i == MAM_WRITE);
   assign read_data_o = read_q;
   assign bte_o       = 2'b00;                // Linear bursts only

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= STATE_IDLE;
         stb_o <= 1'b0;
         cyc_o <= 1'b0;
      end else begin
         state <= nxt_state;
         stb_o <= nxt_stb;
         cyc_o <= nxt_cyc;
      end
      we_o    <= nxt_we;
      cti_o   <= nxt_cti;
      addr_o  <= nxt_addr;
      dat_o   <= nxt_dat;
      sel_o   <= nxt_sel;
      beats   <= nxt_beats;
      burst_q <= nxt_burst;
      read_q  <= nxt_read;
   end

   always_comb begin
      nxt_state     = state;
      nxt_stb       = stb_o;
      nxt_cyc       = cyc_o;
      nxt_we        = we_o;
      nxt_cti       = cti_o;
      nxt_addr      = addr_o;
      nxt_dat       = dat_o;
      nxt_sel       = sel_o;
      nxt_beats     = beats;
      nxt_burst     = burst_q;
      nxt_read      = read_q;
      req_ready_o   = 1'b0;
      write_ready_o = 1'b0;
      read_valid_o  = 1'b0;

      case (state)
         STATE_IDLE: begin
            req_ready_o   = 1'b1;
            write_ready_o = req_valid_i && is_write;  // First word rides with the request
            if (req_valid_i) begin
               nxt_cyc   = 1'b1;
               nxt_we    = is_write;
               nxt_addr  = req_addr_i;
               nxt_burst = req_burst_i;
               nxt_beats = req_burst_i ? req_beats_i : 14'd1;
               nxt_cti   = (nxt_beats == 14'd1) ? CTI_END : CTI_INCR;
               nxt_sel   = req_burst_i ? '1 : write_strb_i;
               if (is_write) begin
                  nxt_stb   = write_valid_i;
                  nxt_dat   = write_data_i;
                  nxt_state = write_state(nxt_beats == 14'd1, write_valid_i);
               end else begin
                  nxt_state = STATE_READ_START;
               end
            end
         end
         STATE_WRITE_WAIT, STATE_WRITE_LAST_WAIT: begin
            write_ready_o = 1'b1;
            if (write_valid_i) begin
               nxt_stb   = 1'b1;
               nxt_dat   = write_data_i;
               nxt_sel   = burst_q ? '1 : write_strb_i;
               nxt_state = write_state(state == STATE_WRITE_LAST_WAIT, 1'b1);
            end
         end
         STATE_WRITE: begin
            if (ack_i) begin
               write_ready_o = 1'b1;                // Next word taken with this ack
               nxt_addr      = addr_o + addr_step;
               nxt_beats     = beats_dec;
               nxt_stb       = write_valid_i;       // No data, stb drops, cyc stays
               nxt_dat       = write_data_i;
               nxt_state     = write_state(beats_dec == 14'd1, write_valid_i);
               if (beats_dec == 14'd1) begin
                  nxt_cti = CTI_END;
               end
            end
         end
         STATE_WRITE_LAST: begin
            if (ack_i) begin
               nxt_addr  = addr_o + addr_step;
               nxt_beats = beats_dec;
               nxt_stb   = 1'b0;
               nxt_cyc   = 1'b0;
               nxt_cti   = CTI_CLASSIC;
               nxt_state = STATE_IDLE;
            end
         end
         STATE_READ_START: begin
            nxt_stb   = 1'b1;
            nxt_state = (beats == 14'd1) ? STATE_READ_LAST : STATE_READ;
         end
         STATE_READ, STATE_READ_LAST, STATE_READ_LAST_BURST: begin
            if (ack_i) begin
               nxt_read  = dat_i;
               nxt_addr  = addr_o + addr_step;
               nxt_beats = beats_dec;
               nxt_stb   = 1'b0;                    // Hold off until the word is taken
               nxt_state = (state == STATE_READ) ? STATE_READ_WAIT : STATE_READ_LAST_WAIT;
               if (beats_dec == 14'd1) begin
                  nxt_cti = CTI_END;
               end
            end
         end
         STATE_READ_WAIT: begin
            read_valid_o = 1'b1;
            if (read_ready_i) begin
               nxt_stb   = 1'b1;
               nxt_state = (beats == 14'd1) ? STATE_READ_LAST_BURST : STATE_READ;
            end
         end
         STATE_READ_LAST_WAIT: begin
            read_valid_o = 1'b1;
            if (read_ready_i) begin
               nxt_cyc   = 1'b0;                    // Bus released after last handshake
               nxt_cti   = CTI_CLASSIC;
               nxt_state = STATE_IDLE;
            end
         end
         default: nxt_state = STATE_IDLE;
      endcase
   end

   a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_o |-> cyc_o)
      else $error("stb_o high outside a bus cycle");

   a_last_beat_cti: assert property (@(posedge clk_i) disable iff (rst_i)
      (stb_o && beats == 14'd1) |-> (cti_o == CTI_END))
      else $error("last beat without end-of-burst cti");

endmodule

// ==== wb_rr_arbiter.sv ====
// ------------------------------------------------
// Round-robin arbiter for two Wishbone masters on
// one slave. A grant lasts for a whole bus cycle
// ------------------------------------------------
`timescale 1ns/1ns
`include "mam_cfg.svh"

module wb_rr_arbiter (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       m0_cyc_i, m0_stb_i, m0_we_i,
   input  logic [`MAM_ADDR_WIDTH-1:0] m0_addr_i,
   input  logic [`MAM_DATA_WIDTH-1:0] m0_dat_i,
   input  logic [`MAM_SEL_WIDTH-1:0]  m0_sel_i,
   input  mam_pkg::wb_cti_e           m0_cti_i,
   input  logic [1:0]                 m0_bte_i,
   output logic                       m0_ack_o,
   output logic [`MAM_DATA_WIDTH-1:0] m0_dat_o,
   input  logic                       m1_cyc_i, m1_stb_i, m1_we_i,
   input  logic [`MAM_ADDR_WIDTH-1:0] m1_addr_i,
   input  logic [`MAM_DATA_WIDTH-1:0] m1_dat_i,
   input  logic [`MAM_SEL_WIDTH-1:0]  m1_sel_i,
   input  mam_pkg::wb_cti_e           m1_cti_i,
   input  logic [1:0]                 m1_bte_i,
   output logic                       m1_ack_o,
   output logic [`MAM_DATA_WIDTH-1:0] m1_dat_o,
   output logic                       s_cyc_o, s_stb_o, s_we_o,
   output logic [`MAM_ADDR_WIDTH-1:0] s_addr_o,
   output logic [`MAM_DATA_WIDTH-1:0] s_dat_o,
   output logic [`MAM_SEL_WIDTH-1:0]  s_sel_o,
   output mam_pkg::wb_cti_e           s_cti_o,
   output logic [1:0]                 s_bte_o,
   input  logic                       s_ack_i,
   input  logic [`MAM_DATA_WIDTH-1:0] s_dat_i
);
   logic grant;                              // 0 selects master a
   logic last_owner;                         // Master that last held a cycle
   logic owner_cyc, other_cyc;

   assign owner_cyc = grant ? m1_cyc_i : m0_cyc_i;
   assign other_cyc = grant ? m0_cyc_i : m1_cyc_i;

   // With the bus free, hand over to a waiting master, else park on
   // the one that did not go last so simultaneous requests alternate
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         grant      <= 1'b0;
         last_owner <= 1'b1;
      end else if (owner_cyc) begin
         last_owner <= grant;
      end else begin
         grant <= other_cyc ? ~grant : ~last_owner;
      end
   end

   assign s_cyc_o  = grant ? m1_cyc_i  : m0_cyc_i;
   assign s_stb_o  = grant ? m1_stb_i  : m0_stb_i;
   assign s_we_o   = grant ? m1_we_i   : m0_we_i;
   assign s_addr_o = grant ? m1_addr_i : m0_addr_i;
   assign s_dat_o  = grant ? m1_dat_i  : m0_dat_i;
   assign s_sel_o  = grant ? m1_sel_i  : m0_sel_i;
   assign s_cti_o  = grant ? m1_cti_i  : m0_cti_i;
   assign s_bte_o  = grant ? m1_bte_i  : m0_bte_i;
   assign m0_ack_o = s_ack_i && !grant;
   assign m1_ack_o = s_ack_i && grant;
   assign m0_dat_o = s_dat_i;                // Only meaningful with ack
   assign m1_dat_o = s_dat_i;

   a_grant_held: assert property (@(posedge clk_i) disable iff (rst_i)
      owner_cyc |=> $stable(grant))
      else $error("grant moved during an owned cycle");

   a_ack_to_owner: assert property (@(posedge clk_i) disable iff (rst_i)
      s_ack_i |-> owner_cyc)
      else $error("slave ack outside the granted cycle");

endmodule

// ==== wb_sram.sv ====
// ------------------------------------------------
// Word-wide on-chip memory as a Wishbone slave.
// Acks one clock after a strobe, with a gap of one
// clock after every ack
// ------------------------------------------------
`timescale 1ns/1ns
`include "mam_cfg.svh"

module wb_sram (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       cyc_i,
   input  logic                       stb_i,
   input  logic                       we_i,
   input  logic [`MAM_ADDR_WIDTH-1:0] addr_i,
   input  logic [`MAM_DATA_WIDTH-1:0] dat_i,
   input  logic [`MAM_SEL_WIDTH-1:0]  sel_i,
   input  mam_pkg::wb_cti_e           cti_i,
   output logic                       ack_o,
   output logic [`MAM_DATA_WIDTH-1:0] dat_o
);
   import mam_pkg::*;

   logic [`MAM_DATA_WIDTH-1:0]        mem [`MAM_MEM_WORDS];
   logic [$clog2(`MAM_MEM_WORDS)-1:0] word_idx;
   logic                              access;

   // Word address, wrapped to the memory depth
   assign word_idx = addr_i[$clog2(`MAM_SEL_WIDTH) +: $clog2(`MAM_MEM_WORDS)];
   assign access   = cyc_i && stb_i && !ack_o;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= access;
      end
   end

   always_ff @(posedge clk_i) begin
      if (access) begin
         dat_o <= mem[word_idx];             // Valid together with ack
      end
      if (ack_o && cyc_i && stb_i && we_i) begin
         for (int b = 0; b < `MAM_SEL_WIDTH; b++) begin
            if (sel_i[b]) begin
               mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
            end
         end
      end
   end

   a_cti_legal: assert property (@(posedge clk_i) disable iff (rst_i)
      (cyc_i && stb_i) |-> (cti_i inside {CTI_CLASSIC, CTI_INCR, CTI_END}))
      else $error("reserved cti value on a strobed beat");

endmodule

// ==== mam_wb_top.sv ====
// ------------------------------------------------
// Debug memory access top. Requesters a and b each
// drive a bridge, the arbiter shares the memory
// ------------------------------------------------
`timescale 1ns/1ns
`include "mam_cfg.svh"

module mam_wb_top (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       a_req_valid_i, b_req_valid_i,
   output logic                       a_req_ready_o, b_req_ready_o,
   input  mam_pkg::mam_op_e           a_req_rw_i, b_req_rw_i,
   input  logic [`MAM_ADDR_WIDTH-1:0] a_req_addr_i, b_req_addr_i,
   input  logic                       a_req_burst_i, b_req_burst_i,
   input  logic [13:0]                a_req_beats_i, b_req_beats_i,
   input  logic                       a_write_valid_i, b_write_valid_i,
   input  logic [`MAM_DATA_WIDTH-1:0] a_write_data_i, b_write_data_i,
   input  logic [`MAM_SEL_WIDTH-1:0]  a_write_strb_i, b_write_strb_i,
   output logic                       a_write_ready_o, b_write_ready_o,
   output logic                       a_read_valid_o, b_read_valid_o,
   output logic [`MAM_DATA_WIDTH-1:0] a_read_data_o, b_read_data_o,
   input  logic                       a_read_ready_i, b_read_ready_i
);
   import mam_pkg::*;

   logic                       a_cyc, a_stb, a_we, a_ack, b_cyc, b_stb, b_we, b_ack;
   logic                       s_cyc, s_stb, s_we, s_ack;
   logic [`MAM_ADDR_WIDTH-1:0] a_addr, b_addr, s_addr;
   logic [`MAM_DATA_WIDTH-1:0] a_dat_w, a_dat_r, b_dat_w, b_dat_r, s_dat_w, s_dat_r;
   logic [`MAM_SEL_WIDTH-1:0]  a_sel, b_sel, s_sel;
   wb_cti_e                    a_cti, b_cti, s_cti;
   logic [1:0]                 a_bte, b_bte;

   mam_wb_if bridge_a (
      .clk_i(clk_i), .rst_i(rst_i), .req_valid_i(a_req_valid_i),
      .req_ready_o(a_req_ready_o), .req_rw_i(a_req_rw_i), .req_addr_i(a_req_addr_i),
      .req_burst_i(a_req_burst_i), .req_beats_i(a_req_beats_i),
      .write_valid_i(a_write_valid_i), .write_data_i(a_write_data_i),
      .write_strb_i(a_write_strb_i), .write_ready_o(a_write_ready_o),
      .read_valid_o(a_read_valid_o), .read_data_o(a_read_data_o),
      .read_ready_i(a_read_ready_i), .stb_o(a_stb), .cyc_o(a_cyc), .we_o(a_we),
      .addr_o(a_addr), .dat_o(a_dat_w), .sel_o(a_sel), .cti_o(a_cti), .bte_o(a_bte),
      .ack_i(a_ack), .dat_i(a_dat_r)
   );

   mam_wb_if bridge_b (
      .clk_i(clk_i), .rst_i(rst_i), .req_valid_i(b_req_valid_i),
      .req_ready_o(b_req_ready_o), .req_rw_i(b_req_rw_i), .req_addr_i(b_req_addr_i),
      .req_burst_i(b_req_burst_i), .req_beats_i(b_req_beats_i),
      .write_valid_i(b_write_valid_i), .write_data_i(b_write_data_i),
      .write_strb_i(b_write_strb_i), .write_ready_o(b_write_ready_o),
      .read_valid_o(b_read_valid_o), .read_data_o(b_read_data_o),
      .read_ready_i(b_read_ready_i), .stb_o(b_stb), .cyc_o(b_cyc), .we_o(b_we),
      .addr_o(b_addr), .dat_o(b_dat_w), .sel_o(b_sel), .cti_o(b_cti), .bte_o(b_bte),
      .ack_i(b_ack), .dat_i(b_dat_r)
   );

   // Bursts are linear, so the slave has no use for bte
   wb_rr_arbiter arbiter (
      .clk_i(clk_i), .rst_i(rst_i),
      .m0_cyc_i(a_cyc), .m0_stb_i(a_stb), .m0_we_i(a_we), .m0_addr_i(a_addr),
      .m0_dat_i(a_dat_w), .m0_sel_i(a_sel), .m0_cti_i(a_cti), .m0_bte_i(a_bte),
      .m0_ack_o(a_ack), .m0_dat_o(a_dat_r),
      .m1_cyc_i(b_cyc), .m1_stb_i(b_stb), .m1_we_i(b_we), .m1_addr_i(b_addr),
      .m1_dat_i(b_dat_w), .m1_sel_i(b_sel), .m1_cti_i(b_cti), .m1_bte_i(b_bte),
      .m1_ack_o(b_ack), .m1_dat_o(b_dat_r),
      .s_cyc_o(s_cyc), .s_stb_o(s_stb), .s_we_o(s_we), .s_addr_o(s_addr),
      .s_dat_o(s_dat_w), .s_sel_o(s_sel), .s_cti_o(s_cti), .s_bte_o(),
      .s_ack_i(s_ack), .s_dat_i(s_dat_r)
   );

   wb_sram memory (
      .clk_i(clk_i), .rst_i(rst_i), .cyc_i(s_cyc), .stb_i(s_stb), .we_i(s_we),
      .addr_i(s_addr), .dat_i(s_dat_w), .sel_i(s_sel), .cti_i(s_cti),
      .ack_o(s_ack), .dat_o(s_dat_r)
   );

endmodule

// ==== tb_mam_wb.sv ====
// ------------------------------------------------
// Self-checking testbench for the two-port debug
// memory access top. A word model follows every
// accepted write and assertions check the reads
// ------------------------------------------------
`timescale 1ns/1ns
`include "mam_cfg.svh"

module tb_mam_wb;
   import mam_pkg::*;

   localparam int WAIT_LIMIT = 2000;          // Cycles per handshake wait

   logic                       clk_i = 1'b0;
   logic                       rst_i;
   logic                       rst_d = 1'b0;  // Reset seen at the previous edge
   logic                       req_valid   [2];
   logic                       req_ready   [2];
   mam_op_e                    req_rw      [2];
   logic [`MAM_ADDR_WIDTH-1:0] req_addr    [2];
   logic                       req_burst   [2];
   logic [13:0]                req_beats   [2];
   logic                       write_valid [2];
   logic [`MAM_DATA_WIDTH-1:0] write_data  [2];
   logic [`MAM_SEL_WIDTH-1:0]  write_strb  [2];
   logic                       write_ready [2];
   logic                       read_valid  [2];
   logic [`MAM_DATA_WIDTH-1:0] read_data   [2];
   logic                       read_ready  [2];
   logic [`MAM_ADDR_WIDTH-1:0] rd_addr     [2];  // Address of the next read word
   logic [`MAM_DATA_WIDTH-1:0] model [`MAM_MEM_WORDS];
   logic [31:0]                rng_state;
   int                         errors = 0;
   int                         reads_checked = 0;
   int                         words_written = 0;

   always #10 clk_i = ~clk_i;

   always @(posedge clk_i) rst_d <= rst_i;

   mam_wb_top dut_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .a_req_valid_i(req_valid[0]), .b_req_valid_i(req_valid[1]),
      .a_req_ready_o(req_ready[0]), .b_req_ready_o(req_ready[1]),
      .a_req_rw_i(req_rw[0]), .b_req_rw_i(req_rw[1]),
      .a_req_addr_i(req_addr[0]), .b_req_addr_i(req_addr[1]),
      .a_req_burst_i(req_burst[0]), .b_req_burst_i(req_burst[1]),
      .a_req_beats_i(req_beats[0]), .b_req_beats_i(req_beats[1]),
      .a_write_valid_i(write_valid[0]), .b_write_valid_i(write_valid[1]),
      .a_write_data_i(write_data[0]), .b_write_data_i(write_data[1]),
      .a_write_strb_i(write_strb[0]), .b_write_strb_i(write_strb[1]),
      .a_write_ready_o(write_ready[0]), .b_write_ready_o(write_ready[1]),
      .a_read_valid_o(read_valid[0]), .b_read_valid_o(read_valid[1]),
      .a_read_data_o(read_data[0]), .b_read_data_o(read_data[1]),
      .a_read_ready_i(read_ready[0]), .b_read_ready_i(read_ready[1])
   );

   // Xorshift generator for data, addresses and stall patterns
   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Word address wrapped to the memory depth
   function automatic int word_of(input logic [`MAM_ADDR_WIDTH-1:0] addr);
      return int'((addr / `MAM_SEL_WIDTH) % `MAM_MEM_WORDS);
   endfunction

   function automatic void apply_write(input logic [`MAM_ADDR_WIDTH-1:0] addr,
                                       input logic [`MAM_DATA_WIDTH-1:0] data,
                                       input logic [`MAM_SEL_WIDTH-1:0]  strb);
      int w;
      int b;
      w = word_of(addr);
      for (b = 0; b < `MAM_SEL_WIDTH; b++) begin
         if (strb[b]) begin
            model[w][8*b +: 8] = data[8*b +: 8];
         end
      end
   endfunction

   task automatic report_timeout(input int p, input string what);
      $display("Timeout: port %s waited %0d cycles for a %s handshake",
               p == 0 ? "a" : "b", WAIT_LIMIT, what);
      $display("Counts: errors %0d, timeouts 1, reads checked %0d, words written %0d",
               errors, reads_checked, words_written);
      $display("SIMULATION FAILED");
      $finish;
   endtask

   // Waits for a request or write handshake, returns 1 ns after its edge
   task automatic wait_accept(input int p, input logic is_req);
      int cycles;
      cycles = 0;
      @(negedge clk_i);
      while (!(is_req ? (req_valid[p] && req_ready[p]) : (write_valid[p] && write_ready[p]))
             && cycles <= WAIT_LIMIT) begin
         cycles++;
         @(negedge clk_i);
      end
      if (cycles > WAIT_LIMIT) begin
         report_timeout(p, is_req ? "request" : "write");
      end else begin
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic write_words(input int p, input logic [`MAM_ADDR_WIDTH-1:0] base,
                              input int beats, input logic [`MAM_SEL_WIDTH-1:0] strb);
      int                         i;
      logic [31:0]                rnd;
      logic [`MAM_ADDR_WIDTH-1:0] addr;
      addr         = base;
      req_rw[p]    = MAM_WRITE;
      req_addr[p]  = base;
      req_burst[p] = (beats > 1);
      req_beats[p] = 14'(beats);
      write_strb[p] = strb;
      req_valid[p] = 1'b1;
      for (i = 0; i < beats; i++) begin
         rnd            = next_rand();
         write_data[p]  = rnd[`MAM_DATA_WIDTH-1:0];
         write_valid[p] = 1'b1;
         wait_accept(p, i == 0);              // First word goes with the request
         req_valid[p] = 1'b0;
         apply_write(addr, write_data[p], beats > 1 ? '1 : strb);
         words_written++;
         addr = addr + `MAM_SEL_WIDTH;
      end
      write_valid[p] = 1'b0;
   endtask

   task automatic read_words(input int p, input logic [`MAM_ADDR_WIDTH-1:0] base,
                             input int beats, input logic stall);
      int          i;
      int          cycles;
      logic [31:0] rnd;
      req_rw[p]    = MAM_READ;
      req_addr[p]  = base;
      req_burst[p] = (beats > 1);
      req_beats[p] = 14'(beats);
      rd_addr[p]   = base;
      req_valid[p] = 1'b1;
      wait_accept(p, 1'b1);
      req_valid[p] = 1'b0;
      for (i = 0; i < beats; i++) begin
         cycles        = 0;
         rnd           = next_rand();
         read_ready[p] = !stall || (rnd[1:0] == 2'b00);  // Ready one cycle in four
         @(negedge clk_i);
         while (!(read_valid[p] && read_ready[p]) && cycles <= WAIT_LIMIT) begin
            @(posedge clk_i);
            #1;
            rnd           = next_rand();
            read_ready[p] = !stall || (rnd[1:0] == 2'b00);
            cycles++;
            @(negedge clk_i);
         end
         if (cycles > WAIT_LIMIT) begin
            report_timeout(p, "read");
         end else begin
            @(posedge clk_i);
            #1;
            rd_addr[p] = rd_addr[p] + `MAM_SEL_WIDTH;
            reads_checked++;
         end
      end
      read_ready[p] = 1'b0;
   endtask

   // Random bursts kept inside the port's own 128-word region
   task automatic random_traffic(input int p, input int rounds);
      int                         n;
      int                         beats;
      int                         offset;
      logic [31:0]                rnd;
      logic [`MAM_ADDR_WIDTH-1:0] base;
      for (n = 0; n < rounds; n++) begin
         rnd    = next_rand();
         beats  = 1 + int'(rnd % 32'd8);
         rnd    = next_rand();
         offset = int'(rnd % 32'(128 - beats));
         base   = 32'(p * 256 + `MAM_SEL_WIDTH * offset);
         write_words(p, base, beats, '1);
         read_words(p, base, beats, 1'b1);
      end
   endtask

   a_reset_quiet: assert property (@(posedge clk_i)
      rst_d |-> (!read_valid[0] && !read_valid[1] && req_ready[0] && req_ready[1]))
      else begin
         errors++;
         $display("At %0t the channels were not idle during or just after reset", $time);
      end

   for (genvar p = 0; p < 2; p++) begin : g_port
      a_read_value: assert property (@(posedge clk_i) disable iff (rst_i)
         (read_valid[p] && read_ready[p]) |-> (read_data[p] == model[word_of(rd_addr[p])]))
         else begin
            errors++;
            $display("ERR %0t %s_read_data_o expected %h actual %h", $time,
                     p == 0 ? "a" : "b", model[word_of(rd_addr[p])], read_data[p]);
         end

      a_read_hold: assert property (@(posedge clk_i) disable iff (rst_i)
         (read_valid[p] && !read_ready[p]) |=> (read_valid[p] && $stable(read_data[p])))
         else begin
            errors++;
            $display("At %0t port %s changed or dropped a read word while the reader stalled",
                     $time, p == 0 ? "a" : "b");
         end
   end

   initial begin
      rng_state = 32'h9608;
      rst_i     = 1'b1;
      for (int p = 0; p < 2; p++) begin
         req_valid[p]   = 1'b0;
         req_rw[p]      = MAM_READ;
         req_addr[p]    = '0;
         req_burst[p]   = 1'b0;
         req_beats[p]   = 14'd1;
         write_valid[p] = 1'b0;
         write_data[p]  = '0;
         write_strb[p]  = '1;
         read_ready[p]  = 1'b0;
         rd_addr[p]     = '0;
      end
      repeat (8) @(posedge clk_i);
      #1;
      rst_i = 1'b0;

      write_words(0, 32'h10, 1, 2'b11);       // Single write and read back
      read_words(0, 32'h10, 1, 1'b0);
      write_words(0, 32'h40, 4, 2'b11);       // Four-beat burst
      read_words(0, 32'h40, 4, 1'b0);
      write_words(0, 32'h10, 1, 2'b01);       // Low byte only
      read_words(0, 32'h10, 1, 1'b0);
      write_words(0, 32'h80, 8, 2'b11);       // Burst read under back-pressure
      read_words(0, 32'h80, 8, 1'b1);

      fork
         random_traffic(0, 6);
         random_traffic(1, 6);
      join

      repeat (4) @(posedge clk_i);
      $display("Counts: errors %0d, timeouts 0, reads checked %0d, words written %0d",
               errors, reads_checked, words_written);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+.
mam_pkg.sv
mam_wb_if.sv
wb_rr_arbiter.sv
wb_sram.sv
mam_wb_top.sv
tb_mam_wb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mam_wb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
